/* bench/quiz_buzzer_tb.sv */
`timescale 1ns/1ps

module quiz_buzzer_tb import buzzer_pkg::*; ();

    typedef enum {WAIT_ARMED, WAIT_WIN, WAIT_FOUL, WAIT_TIMEOUT, WAIT_IDLE} wait_t;

    logic    clk;
    logic    rst;
    player_t btn;
    logic    btn_start;
    logic    btn_clear;
    line_t   row;
    line_t   colr;
    line_t   colg;
    glyph_t  winner;
    logic    foul;
    logic    timeout;
    logic    armed;

    int check_errors = 0;
    int timeout_errors = 0;
    int seed;

    // reference model state
    logic [5:0]   h1, h2, h3, pls;   // clear, start, players
    round_state_t m_state;
    round_state_t ns;
    glyph_t       m_win;
    glyph_t       nw;
    int           m_cnt;
    row_t         m_row;
    logic         q_show, q_green;
    glyph_t       q_glyph;
    line_t        exp_row, exp_colr, exp_colg;

    quiz_buzzer_top quiz_buzzer_top_i (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .btn_start (btn_start),
        .btn_clear (btn_clear),
        .row       (row),
        .colr      (colr),
        .colg      (colg),
        .winner    (winner),
        .foul      (foul),
        .timeout   (timeout),
        .armed     (armed)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // row 0 sits in the top byte and the msb is the left column
    function automatic logic [63:0] glyph_bits(input glyph_t g);
        case (g)
            3'd0:    return 64'h003C_666E_7666_3C00;
            3'd1:    return 64'h0018_3818_1818_7E00;
            3'd2:    return 64'h003C_660C_3060_7E00;
            3'd3:    return 64'h003C_661C_0666_3C00;
            3'd4:    return 64'h000C_1C2C_4C7E_0C00;
            default: return 64'h0;
        endcase
    endfunction

    function automatic line_t glyph_line(input glyph_t g, input row_t r);
        return line_t'(glyph_bits(g) >> (8 * (7 - int'(r))));
    endfunction

    function automatic glyph_t first_player(input player_t p);
        int k;
        k = 0;
        while (k < NUM_PLAYERS && !p[k])
            k++;
        return (k < NUM_PLAYERS) ? glyph_t'(k + 1) : glyph_t'(0);
    endfunction

    function automatic player_t player_bit(input glyph_t p);
        return player_t'(1 << (int'(p) - 1));
    endfunction

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            {h1, h2, h3, pls} <= '0;
            m_state  <= IDLE;
            m_win    <= '0;
            m_cnt    <= 0;
            m_row    <= '0;
            {q_show, q_green, q_glyph} <= '0;
            exp_row  <= '1;
            exp_colr <= '0;
            exp_colg <= '0;
        end
        else
        begin
            ns = m_state;
            nw = m_win;
            if (pls[5])
            begin
                ns = IDLE;
                nw = '0;
            end
            else if (m_state == IDLE && pls[3:0] != '0)
            begin
                ns = FOUL;   // early press
                nw = first_player(pls[3:0]);
            end
            else if (m_state == IDLE && pls[4] && |h2[3:0])
            begin
                ns = FOUL;   // button held through start
                nw = first_player(h2[3:0]);
            end
            else if (m_state == IDLE && pls[4])
                ns = ARMED;
            else if (m_state == ARMED && pls[3:0] != '0)
            begin
                ns = WON;
                nw = first_player(pls[3:0]);
            end
            else if (m_state == ARMED && m_cnt == ANSWER_CYCLES - 1)
                ns = TIMEOUT;
            // three edges from button to pulse
            h1  <= {btn_clear, btn_start, btn};
            h2  <= h1;
            h3  <= h2;
            pls <= h2 & ~h3;
            m_cnt   <= (m_state == ARMED) ? m_cnt + 1 : 0;
            m_state <= ns;
            m_win   <= nw;
            q_show  <= m_state inside {WON, FOUL, TIMEOUT};
            q_green <= (m_state == WON);
            q_glyph <= (m_state == TIMEOUT) ? glyph_t'(0) : m_win;   // timeout shows zero
            m_row   <= m_row + row_t'(1);
            // walking zero that starts on row 0
            exp_row  <= (exp_row == '1) ? 8'hFE : {exp_row[6:0], exp_row[7]};
            exp_colg <= (q_show && q_green) ? glyph_line(q_glyph, m_row) : '0;
            exp_colr <= (q_show && !q_green) ? glyph_line(q_glyph, m_row) : '0;
        end
    end

    task automatic report_mismatch(input string name, input line_t got, input line_t want);
        check_errors++;
        $display("FAILED %s: got %h, expected %h", name, got, want);
    endtask

    row_ok: assert property (@(posedge clk) disable iff (rst) row == exp_row)
        else report_mismatch("row", $sampled(row), $sampled(exp_row));
    colr_ok: assert property (@(posedge clk) disable iff (rst) colr == exp_colr)
        else report_mismatch("colr", $sampled(colr), $sampled(exp_colr));
    colg_ok: assert property (@(posedge clk) disable iff (rst) colg == exp_colg)
        else report_mismatch("colg", $sampled(colg), $sampled(exp_colg));
    winner_ok: assert property (@(posedge clk) disable iff (rst) winner == m_win)
        else report_mismatch("winner", line_t'($sampled(winner)), line_t'($sampled(m_win)));
    foul_ok: assert property (@(posedge clk) disable iff (rst) foul == (m_state == FOUL))
        else report_mismatch("foul", line_t'($sampled(foul)),
                             line_t'($sampled(m_state) == FOUL));
    timeout_ok: assert property (@(posedge clk) disable iff (rst) timeout == (m_state == TIMEOUT))
        else report_mismatch("timeout", line_t'($sampled(timeout)),
                             line_t'($sampled(m_state) == TIMEOUT));
    armed_ok: assert property (@(posedge clk) disable iff (rst) armed == (m_state == ARMED))
        else report_mismatch("armed", line_t'($sampled(armed)),
                             line_t'($sampled(m_state) == ARMED));

    function automatic logic reached(input wait_t w);
        case (w)
            WAIT_ARMED:   return armed;
            WAIT_WIN:     return winner != '0 && !foul;
            WAIT_FOUL:    return foul;
            WAIT_TIMEOUT: return timeout;
            default:      return winner == '0 && !foul && !timeout && !armed
                                 && colr == '0 && colg == '0;
        endcase
    endfunction

    task automatic wait_for(input wait_t w, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!reached(w) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!reached(w))
        begin
            timeout_errors++;
            $display("no %s within %0d cycles", what, limit);
        end
    endtask

    task automatic press_buttons(input player_t b, input int hold);
        @(posedge clk);
        btn <= b;
        repeat (hold) @(posedge clk);
        btn <= '0;
    endtask

    task automatic tap_control(input logic is_clear);
        @(posedge clk);
        if (is_clear)
            btn_clear <= 1'b1;
        else
            btn_start <= 1'b1;
        repeat (2) @(posedge clk);
        btn_clear <= 1'b0;
        btn_start <= 1'b0;
    endtask

    task automatic expect_status(input glyph_t w, input logic f, input logic t);
        @(negedge clk);
        assert (winner == w) else report_mismatch("winner", line_t'(winner), line_t'(w));
        assert (foul == f) else report_mismatch("foul", line_t'(foul), line_t'(f));
        assert (timeout == t) else report_mismatch("timeout", line_t'(timeout), line_t'(t));
        assert (!armed) else report_mismatch("armed", line_t'(armed), 8'h00);
    endtask

    task automatic finish_round();
        tap_control(1'b1);
        wait_for(WAIT_IDLE, 20, "return to idle");
    endtask

    task automatic play_win(input glyph_t p);
        int pause;
        pause = $random(seed) & 15;
        tap_control(1'b0);
        wait_for(WAIT_ARMED, 20, "armed round");
        repeat (pause) @(posedge clk);
        press_buttons(player_bit(p), 3);
        wait_for(WAIT_WIN, 20, "winner");
        expect_status(p, 1'b0, 1'b0);
        repeat (12) @(posedge clk);   // full scan of the green digit
        finish_round();
    endtask

    initial
    begin
        glyph_t pick;
        seed = 46;
        rst <= 1'b1;
        btn <= '0;
        btn_start <= 1'b0;
        btn_clear <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);   // blank scan

        repeat (3) play_win(glyph_t'(($random(seed) & 3) + 1));

        // players 2 and 4 together and then a late press
        tap_control(1'b0);
        wait_for(WAIT_ARMED, 20, "armed round");
        press_buttons(4'b1010, 3);
        wait_for(WAIT_WIN, 20, "winner");
        expect_status(3'd2, 1'b0, 1'b0);
        press_buttons(4'b0001, 3);
        repeat (10) @(posedge clk);
        expect_status(3'd2, 1'b0, 1'b0);
        finish_round();

        pick = glyph_t'(($random(seed) & 3) + 1);
        press_buttons(player_bit(pick), 3);
        wait_for(WAIT_FOUL, 20, "foul");
        expect_status(pick, 1'b1, 1'b0);
        repeat (12) @(posedge clk);

        pick = glyph_t'(($random(seed) & 3) + 1);
        @(posedge clk);
        btn <= player_bit(pick);   // kept down through clear and start
        repeat (6) @(posedge clk);
        finish_round();
        tap_control(1'b0);
        wait_for(WAIT_FOUL, 20, "foul on held button");
        expect_status(pick, 1'b1, 1'b0);
        @(posedge clk);
        btn <= '0;
        repeat (12) @(posedge clk);
        finish_round();

        tap_control(1'b0);
        wait_for(WAIT_ARMED, 20, "armed round");
        wait_for(WAIT_TIMEOUT, ANSWER_CYCLES + 20, "timeout");
        expect_status(3'd0, 1'b0, 1'b1);
        repeat (12) @(posedge clk);   // red zero
        finish_round();

        play_win(glyph_t'(($random(seed) & 3) + 1));

        $display("check errors: %0d, timeout errors: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* project.f */
verilog/buzzer_pkg.sv
verilog/buzz_if.sv
verilog/button_decode.sv
verilog/round_judge.sv
verilog/matrix_scan.sv
verilog/quiz_buzzer_top.sv
bench/quiz_buzzer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the quiz buzzer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module quiz_buzzer_tb -o quiz_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/quiz_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

/* verilog/button_decode.sv */
`timescale 1ns/1ps

module button_decode import buzzer_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  player_t btn,
    input  logic    btn_start,
    input  logic    btn_clear,
    buzz_if.decode  bus
);

    // clear and start on top, players below
    logic [NUM_PLAYERS+1:0] raw;
    logic [NUM_PLAYERS+1:0] sync1;
    logic [NUM_PLAYERS+1:0] sync2;
    logic [NUM_PLAYERS+1:0] prev;
    logic [NUM_PLAYERS+1:0] rise;

    assign raw = {btn_clear, btn_start, btn};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
            rise  <= '0;
        end
        else
        begin
            sync1 <= raw;
            sync2 <= sync1;
            prev  <= sync2;
            rise  <= sync2 & ~prev;   // one cycle per press
        end
    end

    assign bus.press = rise[NUM_PLAYERS-1:0];
    assign bus.start = rise[NUM_PLAYERS];
    assign bus.clear = rise[NUM_PLAYERS+1];

    // synchronized levels, ahead of the press pulse by one cycle
    assign bus.any_press = |sync2[NUM_PLAYERS-1:0];

endmodule

/* verilog/buzz_if.sv */
`timescale 1ns/1ps

interface buzz_if import buzzer_pkg::*; ();

    player_t press;      // per-player rising edge pulses
    logic    start;
    logic    clear;
    logic    any_press;  // level, some player button held

    modport decode (
        output press,
        output start,
        output clear,
        output any_press
    );

    modport judge (
        input press,
        input start,
        input clear,
        input any_press
    );

endinterface

/* verilog/buzzer_pkg.sv */
package buzzer_pkg;

    localparam int NUM_PLAYERS   = 4;
    localparam int ANSWER_CYCLES = 64;   // armed round length in clocks

    // wide enough to hold ANSWER_CYCLES itself
    localparam int CNT_W = $clog2(ANSWER_CYCLES + 1);

    // one bit per player button
    typedef logic [NUM_PLAYERS-1:0] player_t;

    // 0 is the digit zero, 1..4 the player digits
    typedef logic [2:0] glyph_t;

    typedef logic [2:0] row_t;       // scan row index
    typedef logic [7:0] line_t;      // column bits or active-low row select

    typedef logic [CNT_W-1:0] count_t;

    typedef enum logic [2:0] {
        IDLE,
        ARMED,
        WON,
        FOUL,
        TIMEOUT
    } round_state_t;

endpackage

/* verilog/matrix_scan.sv */
`timescale 1ns/1ps

module matrix_scan import buzzer_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   show,
    input  glyph_t glyph,
    input  logic   green,
    output line_t  row,
    output line_t  colr,
    output line_t  colg
);

    logic   show_q;
    logic   green_q;
    glyph_t glyph_q;
    row_t   row_cnt;
    line_t  pat;

    // rows 0 and 7 stay blank, bit 7 is the left column
    function automatic line_t glyph_row(input glyph_t g, input row_t r);
        line_t p;
        p = '0;
        case (g)
            3'd0:
                case (r)
                    3'd1:    p = 8'b0011_1100;
                    3'd2:    p = 8'b0110_0110;
                    3'd3:    p = 8'b0110_1110;
                    3'd4:    p = 8'b0111_0110;
                    3'd5:    p = 8'b0110_0110;
                    3'd6:    p = 8'b0011_1100;
                    default: p = '0;
                endcase
            3'd1:
                case (r)
                    3'd1:    p = 8'b0001_1000;
                    3'd2:    p = 8'b0011_1000;
                    3'd3:    p = 8'b0001_1000;
                    3'd4:    p = 8'b0001_1000;
                    3'd5:    p = 8'b0001_1000;
                    3'd6:    p = 8'b0111_1110;
                    default: p = '0;
                endcase
            3'd2:
                case (r)
                    3'd1:    p = 8'b0011_1100;
                    3'd2:    p = 8'b0110_0110;
                    3'd3:    p = 8'b0000_1100;
                    3'd4:    p = 8'b0011_0000;
                    3'd5:    p = 8'b0110_0000;
                    3'd6:    p = 8'b0111_1110;
                    default: p = '0;
                endcase
            3'd3:
                case (r)
                    3'd1:    p = 8'b0011_1100;
                    3'd2:    p = 8'b0110_0110;
                    3'd3:    p = 8'b0001_1100;
                    3'd4:    p = 8'b0000_0110;
                    3'd5:    p = 8'b0110_0110;
                    3'd6:    p = 8'b0011_1100;
                    default: p = '0;
                endcase
            3'd4:
                case (r)
                    3'd1:    p = 8'b0000_1100;
                    3'd2:    p = 8'b0001_1100;
                    3'd3:    p = 8'b0010_1100;
                    3'd4:    p = 8'b0100_1100;
                    3'd5:    p = 8'b0111_1110;
                    3'd6:    p = 8'b0000_1100;
                    default: p = '0;
                endcase
            default:
                p = '0;   // no glyph beyond player 4
        endcase
        return p;
    endfunction

    // latch the request one edge ahead of the columns
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            show_q  <= 1'b0;
            green_q <= 1'b0;
            glyph_q <= '0;
        end
        else
        begin
            show_q  <= show;
            green_q <= green;
            glyph_q <= glyph;
        end
    end

    assign pat = show_q ? glyph_row(glyph_q, row_cnt) : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= '0;
            row     <= '1;   // all rows off
            colr    <= '0;
            colg    <= '0;
        end
        else
        begin
            row_cnt <= row_cnt + row_t'(1);   // wraps 7 -> 0
            row     <= ~(line_t'(1) << row_cnt);
            colg    <= green_q ? pat : '0;
            colr    <= green_q ? '0 : pat;
        end
    end

endmodule

/* verilog/quiz_buzzer_top.sv */
`timescale 1ns/1ps

module quiz_buzzer_top import buzzer_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  player_t btn,
    input  logic    btn_start,
    input  logic    btn_clear,
    output line_t   row,
    output line_t   colr,
    output line_t   colg,
    output glyph_t  winner,
    output logic    foul,
    output logic    timeout,
    output logic    armed
);

    logic   show;
    logic   green;
    glyph_t glyph;

    buzz_if bus ();

    button_decode button_decode_i (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .btn_start (btn_start),
        .btn_clear (btn_clear),
        .bus       (bus.decode)
    );

    round_judge round_judge_i (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus.judge),
        .show    (show),
        .glyph   (glyph),
        .green   (green),
        .winner  (winner),
        .foul    (foul),
        .timeout (timeout),
        .armed   (armed)
    );

    // digit for the matrix, two edges behind the judge
    matrix_scan matrix_scan_i (
        .clk   (clk),
        .rst   (rst),
        .show  (show),
        .glyph (glyph),
        .green (green),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

/* verilog/round_judge.sv */
`timescale 1ns/1ps

module round_judge import buzzer_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    buzz_if.judge  bus,
    output logic   show,
    output glyph_t glyph,
    output logic   green,
    output glyph_t winner,
    output logic   foul,
    output logic   timeout,
    output logic   armed
);

    round_state_t state;
    round_state_t nxt_state;
    glyph_t       nxt_win;
    count_t       cnt;
    player_t      held;

    // lowest set bit wins, reported as player number 1..4
    function automatic glyph_t lowest(input player_t p);
        glyph_t g;
        g = '0;
        for (int k = NUM_PLAYERS - 1; k >= 0; k--)
        begin
            if (p[k])
                g = glyph_t'(k + 1);
        end
        return g;
    endfunction

    always_comb
    begin
        nxt_state = state;
        nxt_win   = winner;
        if (bus.clear)
        begin
            nxt_state = IDLE;
            nxt_win   = '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (bus.press != '0)
                    begin
                        nxt_state = FOUL;   // pressed before start
                        nxt_win   = lowest(bus.press);
                    end
                    else if (bus.start && bus.any_press)
                    begin
                        // empty held means the press pulse is one cycle away
                        if (held != '0)
                        begin
                            nxt_state = FOUL;
                            nxt_win   = lowest(held);
                        end
                    end
                    else if (bus.start)
                        nxt_state = ARMED;
                end
                ARMED:
                begin
                    if (bus.press != '0)
                    begin
                        nxt_state = WON;
                        nxt_win   = lowest(bus.press);
                    end
                    else if (cnt == count_t'(1))
                        nxt_state = TIMEOUT;
                end
                default:
                    nxt_state = state;   // locked until clear
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= IDLE;
            winner  <= '0;
            cnt     <= '0;
            held    <= '0;
            show    <= 1'b0;
            green   <= 1'b0;
            foul    <= 1'b0;
            timeout <= 1'b0;
            armed   <= 1'b0;
        end
        else
        begin
            state   <= nxt_state;
            winner  <= nxt_win;
            show    <= nxt_state inside {WON, FOUL, TIMEOUT};
            green   <= (nxt_state == WON);
            foul    <= (nxt_state == FOUL);
            timeout <= (nxt_state == TIMEOUT);
            armed   <= (nxt_state == ARMED);
            held    <= bus.any_press ? (held | bus.press) : '0;
            if (nxt_state == ARMED && state != ARMED)
                cnt <= count_t'(ANSWER_CYCLES);
            else if (state == ARMED)
                cnt <= cnt - count_t'(1);
        end
    end

    // winner is already zero in TIMEOUT
    assign glyph = winner;

endmodule
